// ==== rtl/memBusPkg.sv ====
package memBusPkg;

	//////////////////////////////////////////////////////////////////////
	// Bus widths
	//////////////////////////////////////////////////////////////////////

	typedef logic [15:0] addrT;
	typedef logic [15:0] wordT;
	typedef logic [7:0] byteT;
	typedef logic [2:0] waitT;

	// I/O block, decoded ahead of the RAM split on bit 15
	localparam addrT UartDataAddr = 16'hBF00;
	localparam addrT UartStatAddr = 16'hBF01;
	localparam addrT TimingAddr = 16'hBF02;

	//////////////////////////////////////////////////////////////////////
	// Sequencer states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		SramIdle, Setup, Strobe, Hold
	} sramStateT;

	// Read path WaitRx..ReadGap, write path LoadTx..WaitTsre, each run twice
	typedef enum logic [3:0] {
		UartIdle, WaitRx, ReadLow, ReadGap, LoadTx,
		WriteLow, WaitTbre, WaitTsre, Done
	} uartStateT;

endpackage

// ==== rtl/memReqIf.sv ====
interface memReqIf;
	import memBusPkg::*;

	logic req;
	logic we;
	addrT addr;
	wordT wrData;
	// One-cycle pulse, rdData valid alongside
	logic done;
	wordT rdData;

	modport master (
		output req, we, addr, wrData,
		input done, rdData
	);

	modport target (
		input req, we, addr, wrData,
		output done, rdData
	);

endinterface

// ==== rtl/busDecoder.sv ====
module busDecoder (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input memBusPkg::addrT adr,
	input memBusPkg::wordT datWr,
	output memBusPkg::wordT datRd,
	output logic ack,
	memReqIf.master ram1Req,
	memReqIf.master ram2Req,
	memReqIf.master uartReq,
	memReqIf.master regReq
);
	import memBusPkg::*;

	// One-hot select: bit 0 ram1, 1 ram2, 2 uart, 3 timing reg
	logic [3:0] sel;
	logic [3:0] selNext;
	logic busy;
	logic stbHeld;
	logic start;
	logic doneAny;
	addrT addrQ;
	wordT dataQ;
	logic weQ;
	wordT rdMux;

	always_comb begin
		if (adr == UartDataAddr || adr == UartStatAddr)
			selNext = 4'b0100;
		else if (adr == TimingAddr)
			selNext = 4'b1000;
		else if (adr[15])
			selNext = 4'b0001;
		else
			selNext = 4'b0010;
	end

	// New cycle only once the previous stb has gone away
	assign start = cyc && stb && !busy && !stbHeld;
	assign doneAny = ram1Req.done | ram2Req.done | uartReq.done | regReq.done;
	assign rdMux = ({16{sel[0]}} & ram1Req.rdData) | ({16{sel[1]}} & ram2Req.rdData) |
		({16{sel[2]}} & uartReq.rdData) | ({16{sel[3]}} & regReq.rdData);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy <= 1'b0;
			stbHeld <= 1'b0;
			sel <= '0;
			ack <= 1'b0;
		end else begin
			ack <= 1'b0;
			if (!stb)
				stbHeld <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				stbHeld <= 1'b1;
				sel <= selNext;
			end else if (busy && doneAny) begin
				busy <= 1'b0;
				ack <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addrQ <= adr;
			dataQ <= datWr;
			weQ <= we;
		end
		if (busy && doneAny)
			datRd <= rdMux;
	end

	//////////////////////////////////////////////////////////////////////
	// Request fan-out
	//////////////////////////////////////////////////////////////////////

	assign ram1Req.req = busy & sel[0];
	assign ram1Req.addr = addrQ;
	assign ram1Req.wrData = dataQ;
	assign ram1Req.we = weQ;

	assign ram2Req.req = busy & sel[1];
	assign ram2Req.addr = addrQ;
	assign ram2Req.wrData = dataQ;
	assign ram2Req.we = weQ;

	assign uartReq.req = busy & sel[2];
	assign uartReq.addr = addrQ;
	assign uartReq.wrData = dataQ;
	assign uartReq.we = weQ;

	assign regReq.req = busy & sel[3];
	assign regReq.addr = addrQ;
	assign regReq.wrData = dataQ;
	assign regReq.we = weQ;

endmodule

// ==== rtl/sramPort.sv ====
module sramPort (
	input logic clk,
	input logic rst,
	memReqIf.target req,
	input memBusPkg::waitT waitStates,
	output memBusPkg::addrT sramAddr,
	inout wire memBusPkg::wordT sramData,
	output logic sramEn,
	output logic sramOe,
	output logic sramWe
);
	import memBusPkg::*;

	sramStateT state;
	waitT cnt;
	wordT rdQ;
	logic lastStrobe;

	assign lastStrobe = (state == Strobe) && (cnt == '0);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= SramIdle;
			cnt <= '0;
		end else begin
			case (state)
				SramIdle: begin
					if (req.req)
						state <= Setup;
				end
				Setup: begin
					cnt <= waitStates;
					state <= Strobe;
				end
				Strobe: begin
					if (cnt == '0)
						state <= Hold;
					else
						cnt <= cnt - 1'b1;
				end
				Hold: state <= SramIdle;
				default: state <= SramIdle;
			endcase
		end
	end

	// Sample while oe is still low
	always_ff @(posedge clk) begin
		if (lastStrobe && !req.we)
			rdQ <= sramData;
	end

	//////////////////////////////////////////////////////////////////////
	// Chip pins
	//////////////////////////////////////////////////////////////////////

	assign sramAddr = req.addr;
	assign sramEn = (state == SramIdle);
	assign sramOe = !((state == Strobe) && !req.we);
	assign sramWe = !((state == Strobe) && req.we);

	// Write data held from Setup through Hold around the we pulse
	assign sramData = ((state != SramIdle) && req.we) ? req.wrData : 'z;

	assign req.done = (state == Hold);
	assign req.rdData = rdQ;

endmodule

// ==== rtl/uartPort.sv ====
module uartPort (
	input logic clk,
	input logic rst,
	memReqIf.target req,
	inout wire memBusPkg::byteT uartData,
	input logic dataReady,
	output logic rdn,
	input logic tbre,
	input logic tsre,
	output logic wrn
);
	import memBusPkg::*;

	uartStateT state;
	// Set once the high byte has gone through
	logic second;
	byteT txByte;
	wordT rxWord;
	wordT statusWord;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= UartIdle;
			second <= 1'b0;
		end else begin
			case (state)
				UartIdle: begin
					second <= 1'b0;
					if (req.req) begin
						if (req.addr[0])
							state <= Done;
						else if (req.we)
							state <= LoadTx;
						else
							state <= WaitRx;
					end
				end
				WaitRx: if (dataReady) state <= ReadLow;
				ReadLow: state <= ReadGap;
				ReadGap: begin
					second <= 1'b1;
					state <= second ? Done : WaitRx;
				end
				LoadTx: state <= WriteLow;
				WriteLow: state <= WaitTbre;
				WaitTbre: if (tbre) state <= WaitTsre;
				WaitTsre: begin
					if (tsre) begin
						second <= 1'b1;
						state <= second ? Done : LoadTx;
					end
				end
				Done: state <= UartIdle;
				default: state <= UartIdle;
			endcase
		end
	end

	// High byte first in both directions
	always_ff @(posedge clk) begin
		if (state == UartIdle && req.req)
			txByte <= req.wrData[15:8];
		else if (state == WaitTsre && tsre)
			txByte <= req.wrData[7:0];
		if (state == ReadLow) begin
			if (second)
				rxWord[7:0] <= uartData;
			else
				rxWord[15:8] <= uartData;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Chip pins and status
	//////////////////////////////////////////////////////////////////////

	assign rdn = (state != ReadLow);
	assign wrn = (state != WriteLow);
	assign uartData = (state == LoadTx || state == WriteLow) ? txByte : 'z;

	// Bit 1 means holding and shift registers both empty
	assign statusWord = {14'b0, tbre & tsre, dataReady};

	assign req.done = (state == Done);
	assign req.rdData = req.addr[0] ? statusWord : rxWord;

endmodule

// ==== rtl/timingRegs.sv ====
module timingRegs #(
	parameter memBusPkg::waitT ResetWait = 3'd1
) (
	input logic clk,
	input logic rst,
	memReqIf.target req,
	output memBusPkg::waitT waitStates
);
	import memBusPkg::*;

	waitT waitQ;
	logic doneQ;
	logic hit;

	// Accept once per request, the decoder drops req after done
	assign hit = req.req && !doneQ;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			waitQ <= ResetWait;
			doneQ <= 1'b0;
		end else begin
			doneQ <= hit;
			if (hit && req.we)
				waitQ <= req.wrData[2:0];
		end
	end

	assign req.done = doneQ;
	assign req.rdData = {13'b0, waitQ};

	// Shared by both SRAM sequencers
	assign waitStates = waitQ;

endmodule

// ==== rtl/memBusTop.sv ====
module memBusTop #(
	parameter memBusPkg::waitT ResetWait = 3'd1
) (
	input logic clk,
	input logic rst,
	input logic cyc,
	input logic stb,
	input logic we,
	input memBusPkg::addrT adr,
	input memBusPkg::wordT datWr,
	output memBusPkg::wordT datRd,
	output logic ack,
	output memBusPkg::addrT ram1Addr,
	inout wire memBusPkg::wordT ram1Data,
	output logic ram1En,
	output logic ram1Oe,
	output logic ram1We,
	output memBusPkg::addrT ram2Addr,
	inout wire memBusPkg::wordT ram2Data,
	output logic ram2En,
	output logic ram2Oe,
	output logic ram2We,
	inout wire memBusPkg::byteT uartData,
	input logic dataReady,
	output logic rdn,
	input logic tbre,
	input logic tsre,
	output logic wrn
);
	import memBusPkg::*;

	waitT waitStates;

	memReqIf ram1Req ();
	memReqIf ram2Req ();
	memReqIf uartReq ();
	memReqIf regReq ();

	busDecoder decoder (
		.clk, .rst, .cyc, .stb, .we, .adr, .datWr, .datRd, .ack,
		.ram1Req(ram1Req.master), .ram2Req(ram2Req.master),
		.uartReq(uartReq.master), .regReq(regReq.master)
	);

	sramPort ram1Port (
		.clk, .rst, .req(ram1Req.target), .waitStates,
		.sramAddr(ram1Addr), .sramData(ram1Data),
		.sramEn(ram1En), .sramOe(ram1Oe), .sramWe(ram1We)
	);

	sramPort ram2Port (
		.clk, .rst, .req(ram2Req.target), .waitStates,
		.sramAddr(ram2Addr), .sramData(ram2Data),
		.sramEn(ram2En), .sramOe(ram2Oe), .sramWe(ram2We)
	);

	uartPort uart (
		.clk, .rst, .req(uartReq.target),
		.uartData, .dataReady, .rdn, .tbre, .tsre, .wrn
	);

	timingRegs #(.ResetWait(ResetWait)) timing (
		.clk, .rst, .req(regReq.target), .waitStates
	);

endmodule

// ==== bench/benchClock.sv ====
module benchClock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset held over the first three rising edges
	initial begin
		rst = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

// ==== bench/benchModels.sv ====
//////////////////////////////////////////////////////////////////////
// Asynchronous SRAM chip
//////////////////////////////////////////////////////////////////////

module sramModel #(
	parameter memBusPkg::wordT FillKey = 16'h0000
) (
	input memBusPkg::addrT addr,
	inout wire memBusPkg::wordT data,
	input logic en,
	input logic oe,
	input logic we
);
	import memBusPkg::*;

	wordT mem [0:65535];

	// Byte-swapped address under a key, so every cell differs
	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] = {i[7:0], i[15:8]} ^ FillKey;
	end

	always @(posedge we) begin
		if (en === 1'b0)
			mem[addr] = data;
	end

	assign data = (en === 1'b0 && oe === 1'b0) ? mem[addr] : 'z;

endmodule

//////////////////////////////////////////////////////////////////////
// Byte-wide UART chip
//////////////////////////////////////////////////////////////////////

module uartModel (
	input logic clk,
	inout wire memBusPkg::byteT data,
	output logic dataReady,
	input logic rdn,
	output logic tbre,
	output logic tsre,
	input logic wrn,
	input memBusPkg::waitT tbreGap,
	input memBusPkg::waitT tsreGap
);
	import memBusPkg::*;

	byteT rxBuf [0:255];
	int rxHead = 0;
	int rxTail = 0;
	byteT txLog [0:255];
	int txCount = 0;
	byteT txHold;
	logic rdLow = 1'b0;
	logic wrLow = 1'b0;

	initial begin
		tbre = 1'b1;
		tsre = 1'b1;
	end

	task pushRx(input byteT b);
		rxBuf[rxTail % 256] = b;
		rxTail++;
	endtask

	assign dataReady = (rxHead != rxTail);
	assign data = (rdn === 1'b0) ? rxBuf[rxHead % 256] : 'z;

	// Next byte shows up once the read strobe ends
	always @(negedge rdn)
		rdLow = 1'b1;

	always @(posedge rdn) begin
		if (rdLow && rxHead != rxTail)
			rxHead++;
		rdLow = 1'b0;
	end

	// Bus is released as wrn rises, so take the byte on the falling edge
	always @(negedge wrn) begin
		txHold = data;
		wrLow = 1'b1;
	end

	always @(posedge wrn) begin
		if (wrLow) begin
			txLog[txCount % 256] = txHold;
			txCount++;
			wrLow = 1'b0;
			tbre <= 1'b0;
			tsre <= 1'b0;
			repeat (tbreGap) @(posedge clk);
			tbre <= 1'b1;
			repeat (tsreGap) @(posedge clk);
			tsre <= 1'b1;
		end
	end

endmodule

// ==== bench/memBusBench.sv ====
module memBusBench;
	import memBusPkg::*;

	localparam waitT BenchWait = 3'd2;
	localparam wordT Ram1Key = 16'h3c5a;
	localparam wordT Ram2Key = 16'ha5c3;
	localparam int RamWrites = 200;
	localparam int RxWords = 12;
	localparam int TxWords = 12;

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	addrT adr;
	wordT datWr;
	wordT datRd;
	logic ack;
	addrT ram1Addr;
	addrT ram2Addr;
	wire wordT ram1Data;
	wire wordT ram2Data;
	logic ram1En;
	logic ram1Oe;
	logic ram1We;
	logic ram2En;
	logic ram2Oe;
	logic ram2We;
	wire byteT uartData;
	logic dataReady;
	logic rdn;
	logic tbre;
	logic tsre;
	logic wrn;
	waitT tbreGap;
	waitT tsreGap;

	int errors = 0;
	int hsErrors = 0;
	int passCount = 0;
	int failCount = 0;
	int issued = 0;
	int ackCount = 0;
	int cycles = 0;
	int rxPending = 0;
	int txSent = 0;
	waitT expWait;
	logic [31:0] lfsr;
	wordT shadow1 [0:65535];
	wordT shadow2 [0:65535];
	byteT txExpect [0:255];

	benchClock clockGen (.clk, .rst);

	memBusTop #(.ResetWait(BenchWait)) dut0 (
		.clk, .rst, .cyc, .stb, .we, .adr, .datWr, .datRd, .ack,
		.ram1Addr, .ram1Data, .ram1En, .ram1Oe, .ram1We,
		.ram2Addr, .ram2Data, .ram2En, .ram2Oe, .ram2We,
		.uartData, .dataReady, .rdn, .tbre, .tsre, .wrn
	);

	sramModel #(.FillKey(Ram1Key)) ram1Chip (
		.addr(ram1Addr), .data(ram1Data), .en(ram1En), .oe(ram1Oe), .we(ram1We)
	);

	sramModel #(.FillKey(Ram2Key)) ram2Chip (
		.addr(ram2Addr), .data(ram2Data), .en(ram2En), .oe(ram2Oe), .we(ram2We)
	);

	uartModel uartChip (
		.clk, .data(uartData), .dataReady, .rdn, .tbre, .tsre, .wrn, .tbreGap, .tsreGap
	);

	//////////////////////////////////////////////////////////////////////
	// Random source and reference helpers
	//////////////////////////////////////////////////////////////////////

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic wordT fillWord(input addrT a, input wordT key);
		return {a[7:0], a[15:8]} ^ key;
	endfunction

	function automatic addrT randomRamAddr();
		addrT a;
		a = addrT'(takeBits(16));
		// Keep clear of the I/O block
		if (a >= UartDataAddr && a <= TimingAddr)
			a = a ^ 16'h0100;
		return a;
	endfunction

	// Transmitter is always idle between transfers
	function automatic wordT statusExpect();
		return {14'b0, 1'b1, rxPending != 0};
	endfunction

	task automatic checkWord(input string what, input wordT got, input wordT exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic reportTest(input string name, input int startErr);
		if (errors == startErr) begin
			$display("Test %s: ok", name);
			passCount++;
		end else begin
			$display("Test %s: %0d errors", name, errors - startErr);
			failCount++;
		end
	endtask

	// One Wishbone classic cycle with ack sampled on the falling edge
	task automatic busTransfer(input logic wr, input addrT a, input wordT d, output wordT rd);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= wr;
		adr <= a;
		datWr <= d;
		issued++;
		do
			@(negedge clk);
		while (ack !== 1'b1);
		rd = datRd;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
	endtask

	task automatic sramWrite(input addrT a, input wordT d);
		wordT rd;
		busTransfer(1'b1, a, d, rd);
		if (a[15]) begin
			shadow1[a] = d;
			checkWord("ram1 cell after write", ram1Chip.mem[a], d);
			checkWord("ram2 cell untouched", ram2Chip.mem[a], shadow2[a]);
		end else begin
			shadow2[a] = d;
			checkWord("ram2 cell after write", ram2Chip.mem[a], d);
			checkWord("ram1 cell untouched", ram1Chip.mem[a], shadow1[a]);
		end
	endtask

	task automatic sramRead(input addrT a);
		wordT rd;
		busTransfer(1'b0, a, '0, rd);
		checkWord("sram read", rd, a[15] ? shadow1[a] : shadow2[a]);
	endtask

	task automatic pushByte(input byteT b);
		uartChip.pushRx(b);
		rxPending++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic routeRamWrites();
		addrT addrs [0:RamWrites-1];
		int startErr;
		startErr = errors;
		for (int i = 0; i < RamWrites; i++) begin
			addrs[i] = randomRamAddr();
			sramWrite(addrs[i], wordT'(takeBits(16)));
		end
		for (int i = 0; i < RamWrites; i++)
			sramRead(addrs[i]);
		reportTest("sram routing", startErr);
	endtask

	task automatic sweepWaitStates();
		wordT d;
		wordT rd;
		addrT a;
		int startErr;
		startErr = errors;
		busTransfer(1'b0, TimingAddr, '0, rd);
		checkWord("timing reset value", rd, {13'b0, BenchWait});
		// Every wait-state value with random upper bits
		for (int i = 0; i < 8; i++) begin
			d = wordT'(takeBits(16));
			d[2:0] = i[2:0];
			busTransfer(1'b1, TimingAddr, d, rd);
			expWait = d[2:0];
			busTransfer(1'b0, TimingAddr, '0, rd);
			checkWord("timing readback", rd, {13'b0, expWait});
			a = randomRamAddr();
			sramWrite(a, wordT'(takeBits(16)));
			sramRead(a);
		end
		reportTest("timing register", startErr);
	endtask

	task automatic receiveUartWords();
		wordT w;
		wordT rd;
		int gapHigh;
		int gapLow;
		int startErr;
		startErr = errors;
		for (int i = 0; i < RxWords; i++) begin
			w = wordT'(takeBits(16));
			gapHigh = takeBits(6);
			gapLow = takeBits(6);
			fork
				busTransfer(1'b0, UartDataAddr, '0, rd);
				begin
					@(negedge clk);
					repeat (gapHigh) @(negedge clk);
					pushByte(w[15:8]);
					repeat (gapLow) @(negedge clk);
					pushByte(w[7:0]);
				end
			join
			rxPending -= 2;
			checkWord("uart receive", rd, w);
		end
		reportTest("uart receive", startErr);
	endtask

	task automatic sendUartWords();
		wordT w;
		wordT rd;
		int startErr;
		startErr = errors;
		for (int i = 0; i < TxWords; i++) begin
			w = wordT'(takeBits(16));
			tbreGap <= waitT'(takeBits(3));
			tsreGap <= waitT'(takeBits(3));
			busTransfer(1'b1, UartDataAddr, w, rd);
			txExpect[txSent] = w[15:8];
			txExpect[txSent + 1] = w[7:0];
			txSent += 2;
			checkWord("transmit count", wordT'(uartChip.txCount), wordT'(txSent));
			for (int k = txSent - 2; k < txSent; k++)
				checkWord("transmit byte", {8'h00, uartChip.txLog[k]}, {8'h00, txExpect[k]});
		end
		reportTest("uart transmit", startErr);
	endtask

	task automatic probeStatusWord();
		wordT w;
		wordT rd;
		int startErr;
		startErr = errors;
		w = wordT'(takeBits(16));
		@(negedge clk);
		pushByte(w[15:8]);
		busTransfer(1'b0, UartStatAddr, '0, rd);
		checkWord("status with byte waiting", rd, statusExpect());
		@(negedge clk);
		pushByte(w[7:0]);
		busTransfer(1'b0, UartDataAddr, '0, rd);
		rxPending -= 2;
		checkWord("uart receive", rd, w);
		busTransfer(1'b0, UartStatAddr, '0, rd);
		checkWord("status when empty", rd, statusExpect());
		// Write to the status word must be ignored
		busTransfer(1'b1, UartStatAddr, wordT'(takeBits(16)), rd);
		busTransfer(1'b0, UartStatAddr, '0, rd);
		checkWord("status after write", rd, statusExpect());
		busTransfer(1'b0, TimingAddr, '0, rd);
		checkWord("timing after status write", rd, {13'b0, expWait});
		checkWord("transmit count", wordT'(uartChip.txCount), wordT'(txSent));
		reportTest("status word", startErr);
	endtask

	task automatic tallyAcks();
		int startErr;
		startErr = errors;
		assert (ackCount == issued) else begin
			$display("Mismatch at %0t: %0d acks for %0d transfers", $time, ackCount, issued);
			errors++;
		end
		errors += hsErrors;
		reportTest("handshake", startErr);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitors and run control
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		if (ack === 1'b1)
			ackCount++;
		assert (ack !== 1'b1 || stb) else begin
			$display("Acknowledge seen at %0t while strobe was low", $time);
			hsErrors++;
		end
		if (!rst) begin
			assert (ack === 1'b0 && ram1En && ram1Oe && ram1We && ram2En && ram2Oe &&
				ram2We && rdn && wrn) else begin
				$display("Bus outputs active at %0t during reset", $time);
				hsErrors++;
			end
			assert (ram1Data === 16'hzzzz && ram2Data === 16'hzzzz && uartData === 8'hzz)
				else begin
				$display("Data bus driven at %0t during reset", $time);
				hsErrors++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > 400 * issued + 200) begin
			$display("Timeout after %0d cycles with %0d transfers issued", cycles, issued);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datWr = '0;
		tbreGap = '0;
		tsreGap = '0;
		lfsr = 32'h2ec5_c850;
		expWait = BenchWait;
		for (int i = 0; i < 65536; i++) begin
			shadow1[i] = fillWord(addrT'(i), Ram1Key);
			shadow2[i] = fillWord(addrT'(i), Ram2Key);
		end
		wait (rst === 1'b1);
		routeRamWrites();
		sweepWaitStates();
		receiveUartWords();
		sendUartWords();
		probeStatusWord();
		tallyAcks();
		$display("Tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== src.f ====
rtl/memBusPkg.sv
rtl/memReqIf.sv
rtl/busDecoder.sv
rtl/sramPort.sv
rtl/uartPort.sv
rtl/timingRegs.sv
rtl/memBusTop.sv
bench/benchClock.sv
bench/benchModels.sv
bench/memBusBench.sv
